//--- source/memStagePkg.sv
/*
 * Shared types for the memory stage: data widths, bundles between stages,
 * coprocessor-0 fields, exception codes and exception vectors.
 */
`default_nettype none

package memStagePkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  regIdx_t;   // gpr index or cp0 register number
    typedef logic [4:0]  excCode_t;  // Cause.ExcCode

    typedef enum logic [2:0] {
        LD_NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W
    } loadType_t;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_B,
        ST_H,
        ST_W
    } storeType_t;

    localparam excCode_t EXC_INT  = 5'd0;
    localparam excCode_t EXC_ADEL = 5'd4;
    localparam excCode_t EXC_ADES = 5'd5;
    localparam excCode_t EXC_SYS  = 5'd8;
    localparam excCode_t EXC_BP   = 5'd9;
    localparam excCode_t EXC_RI   = 5'd10;
    localparam excCode_t EXC_OV   = 5'd12;

    // flags gathered in fetch, decode and execute
    typedef struct packed {
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic overflow;
        logic eret;
    } exceptPipe_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       aluOut;     // effective address or alu result
        word_t       storeData;
        loadType_t   loadType;
        storeType_t  storeType;
        regIdx_t     dst;
        logic        regWrite;
        logic        cp0Write;   // mtc0
        logic        cp0Read;    // mfc0
        regIdx_t     cp0Addr;
        logic        isBranch;   // branch or jump
        exceptPipe_t except;
    } exeMemBus_t;

    typedef struct packed {
        logic       read;
        logic       write;
        word_t      physAddr;
        logic [3:0] wstrb;
        word_t      wdata;
        logic       cached;
    } dmemReq_t;

    // to forwarding and write-back
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        regIdx_t   dst;
        logic      regWrite;
        loadType_t loadType;
    } memResult_t;

    typedef struct packed {
        logic       bev;
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } cp0Status_t;

    localparam regIdx_t CP0_BADVADDR = 5'd8;
    localparam regIdx_t CP0_STATUS   = 5'd12;
    localparam regIdx_t CP0_CAUSE    = 5'd13;
    localparam regIdx_t CP0_EPC      = 5'd14;

    localparam word_t VEC_BOOT   = 32'hBFC0_0380;
    localparam word_t VEC_NORMAL = 32'h8000_0180;

endpackage

`default_nettype wire

//--- source/memStageReg.sv
/*
 * Execute-to-memory pipeline register. memWr loads, flush empties,
 * and the delay-slot flag follows the last valid instruction loaded.
 */
`timescale 1ns/1ps
`default_nettype none

module memStageReg (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    memWr,
    input  memStagePkg::exeMemBus_t exeIn,
    output memStagePkg::exeMemBus_t stageBus,
    output logic                    inDelaySlot
);

    logic lastBranch;  // previous valid instruction was a branch or jump

    // flush wins over the load enable, payload simply holds
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            stageBus.valid <= 1'b0;
        end else if (memWr) begin
            stageBus <= exeIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            lastBranch  <= 1'b0;
            inDelaySlot <= 1'b0;
        end else if (memWr && exeIn.valid) begin
            inDelaySlot <= lastBranch;      // slot follows the branch
            lastBranch  <= exeIn.isBranch;
        end
    end

    // a flushed stage never presents a valid instruction
    flushEmpties: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !stageBus.valid
    );

endmodule

`default_nettype wire

//--- source/dataAddrMap.sv
/*
 * Fixed segment mapping for data addresses plus alignment checks.
 * kseg0 is cached, kseg1 uncached, everything else passes through cached.
 */
`timescale 1ns/1ps
`default_nettype none

module dataAddrMap (
    input  memStagePkg::word_t      virtAddr,
    input  memStagePkg::loadType_t  loadType,
    input  memStagePkg::storeType_t storeType,
    output memStagePkg::word_t      physAddr,
    output logic                    cached,
    output logic                    loadAddrErr,
    output logic                    storeAddrErr
);

    logic halfMis;
    logic wordMis;

    always_comb begin
        physAddr = virtAddr;
        cached   = 1'b1;
        unique case (virtAddr[31:29])
            3'b100: physAddr = {1'b0, virtAddr[30:0]};  // kseg0
            3'b101: begin                               // kseg1
                physAddr = {3'b000, virtAddr[28:0]};
                cached   = 1'b0;
            end
            default: ;  // kuseg and kseg2/3 unmapped here
        endcase
    end

    assign halfMis = virtAddr[0];
    assign wordMis = |virtAddr[1:0];

    always_comb begin
        unique case (loadType)
            memStagePkg::LD_H,
            memStagePkg::LD_HU: loadAddrErr = halfMis;
            memStagePkg::LD_W:  loadAddrErr = wordMis;
            default:            loadAddrErr = 1'b0;  // bytes never misalign
        endcase
    end

    always_comb begin
        unique case (storeType)
            memStagePkg::ST_H: storeAddrErr = halfMis;
            memStagePkg::ST_W: storeAddrErr = wordMis;
            default:           storeAddrErr = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/storeLaneAlign.sv
/*
 * Byte-lane strobes and lane-replicated write data for stores.
 * Data is copied across lanes so the strobe alone selects the bytes.
 */
`timescale 1ns/1ps
`default_nettype none

module storeLaneAlign (
    input  logic [1:0]              addrLow,
    input  memStagePkg::storeType_t storeType,
    input  memStagePkg::word_t      storeData,
    output logic [3:0]              wstrb,
    output memStagePkg::word_t      wdata
);

    always_comb begin
        unique case (storeType)
            memStagePkg::ST_B: begin
                wstrb = 4'b0001 << addrLow;        // one lane by address
                wdata = {4{storeData[7:0]}};
            end
            memStagePkg::ST_H: begin
                wstrb = addrLow[1] ? 4'b1100 : 4'b0011;
                wdata = {2{storeData[15:0]}};
            end
            memStagePkg::ST_W: begin
                wstrb = 4'b1111;
                wdata = storeData;
            end
            default: begin
                wstrb = 4'b0000;                   // not a store
                wdata = storeData;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/cp0Regs.sv
/*
 * Reduced coprocessor 0: BadVAddr, Status, Cause and EPC.
 * Updated by mtc0, by taken exceptions and by eret on the clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module cp0Regs #(
    parameter bit RESET_BEV = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [5:0]              interrupt,
    input  logic                    writeEn,
    input  memStagePkg::regIdx_t    addr,
    input  memStagePkg::word_t      writeData,
    output memStagePkg::word_t      readData,
    input  logic                    except,
    input  memStagePkg::excCode_t   excCode,
    input  memStagePkg::word_t      pc,
    input  logic                    inDelaySlot,
    input  memStagePkg::word_t      badAddr,
    input  logic                    badAddrValid,
    input  logic                    eret,
    output memStagePkg::cp0Status_t status,
    output logic [7:0]              causeIp,
    output memStagePkg::word_t      epc
);

    memStagePkg::word_t    badVAddr;
    memStagePkg::excCode_t causeExc;
    logic                  causeBd;
    logic [7:2]            causeIpHw;  // hardware lines
    logic [1:0]            causeIpSw;  // software interrupts

    always_ff @(posedge clk) begin
        if (reset) begin
            status    <= '{bev: RESET_BEV, im: 8'h00, exl: 1'b0, ie: 1'b0};
            causeBd   <= 1'b0;
            causeExc  <= '0;
            causeIpHw <= '0;
            causeIpSw <= '0;
            epc       <= '0;
        end else begin
            causeIpHw <= interrupt;  // sampled every cycle
            if (writeEn) begin
                unique case (addr)
                    memStagePkg::CP0_STATUS: begin
                        status.bev <= writeData[22];
                        status.im  <= writeData[15:8];
                        status.exl <= writeData[1];
                        status.ie  <= writeData[0];
                    end
                    memStagePkg::CP0_CAUSE: causeIpSw <= writeData[9:8];
                    memStagePkg::CP0_EPC:   epc       <= writeData;
                    default: ;  // BadVAddr is read only
                endcase
            end
            if (except) begin
                epc        <= inDelaySlot ? pc - 32'd4 : pc;  // restart at the branch
                causeBd    <= inDelaySlot;
                causeExc   <= excCode;
                status.exl <= 1'b1;
            end else if (eret) begin
                status.exl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (except && badAddrValid) begin
            badVAddr <= badAddr;
        end
    end

    assign causeIp = {causeIpHw, causeIpSw};

    always_comb begin
        unique case (addr)
            memStagePkg::CP0_BADVADDR: readData = badVAddr;
            memStagePkg::CP0_STATUS:
                readData = {9'b0, status.bev, 6'b0, status.im, 6'b0, status.exl, status.ie};
            memStagePkg::CP0_CAUSE:
                readData = {causeBd, 15'b0, causeIp, 1'b0, causeExc, 2'b0};
            memStagePkg::CP0_EPC:      readData = epc;
            default:                   readData = '0;
        endcase
    end

    // the arbiter hands over either an exception or an eret, never both
    exceptOrEret: assert property (
        @(posedge clk) disable iff (reset)
        !(except && eret)
    );

endmodule

`default_nettype wire

//--- source/exceptionArbiter.sv
/*
 * Picks the highest-priority exception of the instruction in the memory
 * stage and decides flush, exception code and target vector.
 */
`timescale 1ns/1ps
`default_nettype none

module exceptionArbiter (
    input  logic                     valid,
    input  memStagePkg::exceptPipe_t pipeExcept,
    input  logic                     loadAddrErr,
    input  logic                     storeAddrErr,
    input  memStagePkg::cp0Status_t  status,
    input  logic [7:0]               causeIp,
    input  memStagePkg::word_t       epc,
    output logic                     exceptFlush,
    output logic                     except,
    output memStagePkg::excCode_t    excCode,
    output logic                     badAddrValid,
    output logic                     eret,
    output memStagePkg::word_t       exceptVector
);

    logic intPending;

    assign intPending = status.ie && !status.exl && |(causeIp & status.im);

    // highest priority first
    always_comb begin
        except       = 1'b0;
        excCode      = memStagePkg::EXC_INT;
        badAddrValid = 1'b0;
        eret         = 1'b0;
        if (valid) begin
            if (intPending) begin
                except = 1'b1;
            end else if (pipeExcept.fetchAddrErr) begin
                except       = 1'b1;
                excCode      = memStagePkg::EXC_ADEL;
                badAddrValid = 1'b1;  // bad address is the pc
            end else if (pipeExcept.reservedInstr) begin
                except  = 1'b1;
                excCode = memStagePkg::EXC_RI;
            end else if (pipeExcept.overflow) begin
                except  = 1'b1;
                excCode = memStagePkg::EXC_OV;
            end else if (pipeExcept.syscall) begin
                except  = 1'b1;
                excCode = memStagePkg::EXC_SYS;
            end else if (pipeExcept.brk) begin
                except  = 1'b1;
                excCode = memStagePkg::EXC_BP;
            end else if (loadAddrErr) begin
                except       = 1'b1;
                excCode      = memStagePkg::EXC_ADEL;
                badAddrValid = 1'b1;
            end else if (storeAddrErr) begin
                except       = 1'b1;
                excCode      = memStagePkg::EXC_ADES;
                badAddrValid = 1'b1;
            end else if (pipeExcept.eret) begin
                eret = 1'b1;
            end
        end
    end

    assign exceptFlush  = except || eret;
    assign exceptVector = eret       ? epc :
                          status.bev ? memStagePkg::VEC_BOOT : memStagePkg::VEC_NORMAL;

endmodule

`default_nettype wire

//--- source/memStageTop.sv
/*
 * Memory stage top: stage register, address mapping, store alignment,
 * coprocessor 0 and exception handling. Builds the dmem request and result.
 */
`timescale 1ns/1ps
`default_nettype none

module memStageTop #(
    parameter bit RESET_BEV = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    memWr,
    input  logic                    disableWrite,
    input  logic [5:0]              interrupt,
    input  memStagePkg::exeMemBus_t exeIn,
    output memStagePkg::dmemReq_t   dmemReq,
    output memStagePkg::memResult_t memOut,
    output logic                    exceptFlush,
    output memStagePkg::word_t      exceptVector,
    output memStagePkg::word_t      epc
);

    memStagePkg::exeMemBus_t  stageBus;
    logic                     inDelaySlot;
    memStagePkg::word_t       physAddr;
    logic                     cached;
    logic                     loadAddrErr;
    logic                     storeAddrErr;
    logic [3:0]               wstrb;
    memStagePkg::word_t       wdata;
    memStagePkg::cp0Status_t  status;
    logic [7:0]               causeIp;
    memStagePkg::word_t       cp0ReadData;
    logic                     except;
    memStagePkg::excCode_t    excCode;
    logic                     badAddrValid;
    logic                     eret;
    memStagePkg::word_t       badAddr;
    logic                     sideEffectOk;  // instruction may touch memory and cp0

    memStageReg uStageReg (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .memWr       (memWr),
        .exeIn       (exeIn),
        .stageBus    (stageBus),
        .inDelaySlot (inDelaySlot)
    );

    dataAddrMap uAddrMap (
        .virtAddr     (stageBus.aluOut),
        .loadType     (stageBus.loadType),
        .storeType    (stageBus.storeType),
        .physAddr     (physAddr),
        .cached       (cached),
        .loadAddrErr  (loadAddrErr),
        .storeAddrErr (storeAddrErr)
    );

    storeLaneAlign uLaneAlign (
        .addrLow   (stageBus.aluOut[1:0]),
        .storeType (stageBus.storeType),
        .storeData (stageBus.storeData),
        .wstrb     (wstrb),
        .wdata     (wdata)
    );

    exceptionArbiter uArbiter (
        .valid        (stageBus.valid),
        .pipeExcept   (stageBus.except),
        .loadAddrErr  (loadAddrErr),
        .storeAddrErr (storeAddrErr),
        .status       (status),
        .causeIp      (causeIp),
        .epc          (epc),
        .exceptFlush  (exceptFlush),
        .except       (except),
        .excCode      (excCode),
        .badAddrValid (badAddrValid),
        .eret         (eret),
        .exceptVector (exceptVector)
    );

    // fetch faults report the pc, data faults the effective address
    assign badAddr      = stageBus.except.fetchAddrErr ? stageBus.pc : stageBus.aluOut;
    assign sideEffectOk = stageBus.valid && !exceptFlush && !disableWrite;

    cp0Regs #(
        .RESET_BEV (RESET_BEV)
    ) uCp0 (
        .clk          (clk),
        .reset        (reset),
        .interrupt    (interrupt),
        .writeEn      (sideEffectOk && stageBus.cp0Write),  // mtc0 only when committed
        .addr         (stageBus.cp0Addr),
        .writeData    (stageBus.storeData),
        .readData     (cp0ReadData),
        .except       (except && !disableWrite),
        .excCode      (excCode),
        .pc           (stageBus.pc),
        .inDelaySlot  (inDelaySlot),
        .badAddr      (badAddr),
        .badAddrValid (badAddrValid),
        .eret         (eret && !disableWrite),
        .status       (status),
        .causeIp      (causeIp),
        .epc          (epc)
    );

    always_comb begin
        dmemReq.read     = sideEffectOk && (stageBus.loadType != memStagePkg::LD_NONE);
        dmemReq.write    = sideEffectOk && (stageBus.storeType != memStagePkg::ST_NONE);
        dmemReq.physAddr = physAddr;
        dmemReq.wstrb    = wstrb;
        dmemReq.wdata    = wdata;
        dmemReq.cached   = cached;
    end

    always_comb begin
        memOut.valid    = stageBus.valid;
        memOut.pc       = stageBus.pc;
        memOut.result   = stageBus.cp0Read ? cp0ReadData : stageBus.aluOut;  // mfc0 bypass
        memOut.dst      = stageBus.dst;
        memOut.regWrite = stageBus.regWrite && !exceptFlush && !disableWrite;
        memOut.loadType = stageBus.loadType;
    end

endmodule

`default_nettype wire

//--- verif/memStageTb.sv
/*
 * Directed testbench for the memory stage top. Each test issues bundles through
 * the stage register and checks dmem requests, exceptions and cp0 state via mfc0.
 */
`timescale 1ns/1ps
`default_nettype none

module memStageTb;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;             // after the rising edge
    localparam int ISSUE_SLOTS = 44;            // bundles issued over all tests
    localparam int MAX_CYCLES  = 4 + 2 * ISSUE_SLOTS + 50;

    logic                    clk;
    logic                    reset;
    logic                    flush;
    logic                    memWr;
    logic                    disableWrite;
    logic [5:0]              interrupt;
    memStagePkg::exeMemBus_t exeIn;
    memStagePkg::dmemReq_t   dmemReq;
    memStagePkg::memResult_t memOut;
    logic                    exceptFlush;
    memStagePkg::word_t      exceptVector;
    memStagePkg::word_t      epc;

    integer seed = 26;
    int     checks = 0;
    int     errors = 0;
    string  testName = "reset";

    memStageTop dut (
        .clk(clk), .reset(reset), .flush(flush), .memWr(memWr),
        .disableWrite(disableWrite), .interrupt(interrupt), .exeIn(exeIn),
        .dmemReq(dmemReq), .memOut(memOut), .exceptFlush(exceptFlush),
        .exceptVector(exceptVector), .epc(epc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // reference model, straight from the segment and cp0 layout rules
    function automatic memStagePkg::word_t physOf(input memStagePkg::word_t a);
        if (a[31:29] == 3'b100) return a & 32'h7FFF_FFFF;  // kseg0
        if (a[31:29] == 3'b101) return a & 32'h1FFF_FFFF;  // kseg1
        return a;
    endfunction

    // access size in bytes: 1 byte, 2 half, 3 word
    function automatic int bytesOf(input int kind);
        if (kind == 1) return 1;
        if (kind == 2) return 2;
        return 4;
    endfunction

    // lanes covered by the access starting at the low address bits
    function automatic logic [3:0] strobeOf(input int kind, input logic [1:0] low);
        int         size;
        logic [3:0] s;
        size = bytesOf(kind);
        for (int lane = 0; lane < 4; lane++) begin
            s[lane] = (lane >= int'(low)) && (lane < int'(low) + size);
        end
        return s;
    endfunction

    // every lane carries the store byte that would land in it
    function automatic memStagePkg::word_t laneDataOf(input int kind,
                                                      input memStagePkg::word_t d);
        int                 size;
        memStagePkg::word_t w;
        size = bytesOf(kind);
        for (int lane = 0; lane < 4; lane++) begin
            w[8 * lane +: 8] = d[8 * (lane % size) +: 8];
        end
        return w;
    endfunction

    function automatic memStagePkg::word_t statusWord(input logic bev, input logic [7:0] im,
                                                      input logic exl, input logic ie);
        return (32'(bev) << 22) | (32'(im) << 8) | (32'(exl) << 1) | 32'(ie);
    endfunction

    function automatic memStagePkg::exeMemBus_t nopBundle();
        memStagePkg::exeMemBus_t b;
        b = '0;  // valid low, no load, no store
        return b;
    endfunction

    function automatic memStagePkg::exeMemBus_t instrAt(input memStagePkg::word_t pc);
        memStagePkg::exeMemBus_t b;
        b = nopBundle();
        b.valid = 1'b1;
        b.pc    = pc;
        return b;
    endfunction

    task automatic checkEq(input string what, input memStagePkg::word_t expected,
                           input memStagePkg::word_t actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    // one cycle in the stage, then a bubble; returns in the middle of that cycle
    task automatic issue(input memStagePkg::exeMemBus_t b, input logic dis);
        @(posedge clk);
        #DRIVE_DELAY;
        exeIn        = b;
        memWr        = 1'b1;
        disableWrite = dis;
        @(posedge clk);
        #DRIVE_DELAY;
        exeIn = nopBundle();
        @(negedge clk);
    endtask

    task automatic writeCp0(input memStagePkg::regIdx_t idx, input memStagePkg::word_t data,
                            input logic dis);
        memStagePkg::exeMemBus_t b;
        b          = instrAt(32'h8000_1000);
        b.cp0Write = 1'b1;
        b.cp0Addr  = idx;
        b.storeData = data;
        issue(b, dis);
    endtask

    task automatic readCp0(input memStagePkg::regIdx_t idx, output memStagePkg::word_t value);
        memStagePkg::exeMemBus_t b;
        b          = instrAt(32'h8000_1004);
        b.cp0Read  = 1'b1;
        b.cp0Addr  = idx;
        b.regWrite = 1'b1;
        b.dst      = 5'd2;
        issue(b, 1'b0);
        value = memOut.result;
    endtask

    task automatic driveIrq(input logic [5:0] lines);
        @(posedge clk);
        #DRIVE_DELAY;
        interrupt = lines;
    endtask

    task automatic storesAndMapping();
        memStagePkg::exeMemBus_t b;
        memStagePkg::word_t      addr;
        memStagePkg::word_t      data;
        logic [1:0]              low;
        testName = "storesAndMapping";
        for (int s = 0; s < 3; s++) begin
            for (int kind = 1; kind <= 3; kind++) begin
                data = $random(seed);
                low  = $random(seed);
                if (kind == 2) low[0] = 1'b0;
                if (kind == 3) low = 2'b00;
                addr = (s == 0) ? 32'h8000_0000 : (s == 1) ? 32'hA000_0000 : 32'h0;
                addr = addr | ($random(seed) & 32'h0FFF_FFFC) | 32'(low);
                b           = instrAt(32'h8000_0100 + 32'(4 * kind));
                b.aluOut    = addr;
                b.storeData = data;
                b.storeType = memStagePkg::storeType_t'(kind);
                issue(b, 1'b0);
                checkEq("write", 1, dmemReq.write);
                checkEq("read", 0, dmemReq.read);
                checkEq("wstrb", strobeOf(kind, low), dmemReq.wstrb);
                checkEq("wdata", laneDataOf(kind, data), dmemReq.wdata);
                checkEq("physAddr", physOf(addr), dmemReq.physAddr);
                checkEq("cached", addr[31:29] != 3'b101, dmemReq.cached);
                checkEq("flush", 0, exceptFlush);
            end
        end
        b          = instrAt(32'h8000_0200);
        b.aluOut   = 32'hA000_0000 | ($random(seed) & 32'h1FFF_FFFC);
        b.loadType = memStagePkg::LD_W;
        b.regWrite = 1'b1;
        b.dst      = 5'd7;
        issue(b, 1'b0);
        checkEq("load read", 1, dmemReq.read);
        checkEq("load write", 0, dmemReq.write);
        checkEq("load physAddr", physOf(b.aluOut), dmemReq.physAddr);
        checkEq("load valid", 1, memOut.valid);
        checkEq("load pc", 32'h8000_0200, memOut.pc);
        checkEq("load dst", 5'd7, memOut.dst);
        checkEq("load regWrite", 1, memOut.regWrite);
        checkEq("load loadType", memStagePkg::LD_W, memOut.loadType);
    endtask

    task automatic misalignedCase(input logic isStore, input memStagePkg::word_t pc,
                                  input memStagePkg::word_t addr);
        memStagePkg::exeMemBus_t b;
        memStagePkg::word_t      value;
        b          = instrAt(pc);
        b.aluOut   = addr;
        b.regWrite = 1'b1;
        if (isStore) b.storeType = memStagePkg::ST_H;
        else         b.loadType  = memStagePkg::LD_W;
        issue(b, 1'b0);
        checkEq("flush", 1, exceptFlush);
        checkEq("read", 0, dmemReq.read);
        checkEq("write", 0, dmemReq.write);
        checkEq("regWrite", 0, memOut.regWrite);
        checkEq("vector", memStagePkg::VEC_BOOT, exceptVector);
        readCp0(memStagePkg::CP0_EPC, value);
        checkEq("EPC", pc, value);
        readCp0(memStagePkg::CP0_CAUSE, value);
        checkEq("ExcCode", isStore ? memStagePkg::EXC_ADES : memStagePkg::EXC_ADEL, value[6:2]);
        readCp0(memStagePkg::CP0_BADVADDR, value);
        checkEq("BadVAddr", addr, value);
        readCp0(memStagePkg::CP0_STATUS, value);
        checkEq("EXL", 1, value[1]);
    endtask

    task automatic mtc0RoundTrip();
        memStagePkg::exeMemBus_t b;
        memStagePkg::word_t      value;
        memStagePkg::word_t      saved;
        testName = "mtc0RoundTrip";
        writeCp0(memStagePkg::CP0_STATUS, statusWord(1'b1, 8'hA5, 1'b0, 1'b0), 1'b0);
        readCp0(memStagePkg::CP0_STATUS, value);
        checkEq("Status", statusWord(1'b1, 8'hA5, 1'b0, 1'b0), value);
        saved = $random(seed);
        writeCp0(memStagePkg::CP0_EPC, saved, 1'b0);
        readCp0(memStagePkg::CP0_EPC, value);
        checkEq("EPC", saved, value);
        writeCp0(memStagePkg::CP0_EPC, ~saved, 1'b1);  // stalled, must not land
        readCp0(memStagePkg::CP0_EPC, value);
        checkEq("EPC held", saved, value);
        b           = instrAt(32'h8000_0300);
        b.aluOut    = 32'h8000_0040;
        b.storeType = memStagePkg::ST_W;
        issue(b, 1'b1);
        checkEq("stalled write", 0, dmemReq.write);
    endtask

    task automatic interruptAndEret();
        memStagePkg::exeMemBus_t b;
        memStagePkg::word_t      value;
        testName = "interruptAndEret";
        writeCp0(memStagePkg::CP0_STATUS, statusWord(1'b1, 8'h00, 1'b0, 1'b1), 1'b0);
        driveIrq(6'b000001);
        b          = instrAt(32'h8000_0400);
        b.aluOut   = 32'h1234_5678;
        b.regWrite = 1'b1;
        issue(b, 1'b0);
        checkEq("masked flush", 0, exceptFlush);
        checkEq("masked regWrite", 1, memOut.regWrite);
        checkEq("result", 32'h1234_5678, memOut.result);
        writeCp0(memStagePkg::CP0_STATUS, statusWord(1'b1, 8'h04, 1'b0, 1'b1), 1'b0);
        b.pc = 32'h8000_0410;
        issue(b, 1'b0);
        checkEq("irq flush", 1, exceptFlush);
        checkEq("irq regWrite", 0, memOut.regWrite);
        checkEq("irq vector", memStagePkg::VEC_BOOT, exceptVector);
        driveIrq(6'b000000);  // commit edge of the interrupt
        checkEq("epc port", 32'h8000_0410, epc);
        readCp0(memStagePkg::CP0_CAUSE, value);
        checkEq("ExcCode", memStagePkg::EXC_INT, value[6:2]);
        b = instrAt(32'h8000_0500);
        b.except.eret = 1'b1;
        issue(b, 1'b0);
        checkEq("eret flush", 1, exceptFlush);
        checkEq("eret vector", 32'h8000_0410, exceptVector);
        readCp0(memStagePkg::CP0_STATUS, value);
        checkEq("Status after eret", statusWord(1'b1, 8'h04, 1'b0, 1'b1), value);
        writeCp0(memStagePkg::CP0_STATUS, statusWord(1'b1, 8'h00, 1'b0, 1'b0), 1'b0);
    endtask

    task automatic delaySlotFault();
        memStagePkg::exeMemBus_t b;
        memStagePkg::word_t      value;
        testName = "delaySlotFault";
        b = instrAt(32'h8000_3000);
        b.isBranch = 1'b1;
        issue(b, 1'b0);
        checkEq("branch flush", 0, exceptFlush);
        b = instrAt(32'h8000_3004);
        b.except.reservedInstr = 1'b1;
        issue(b, 1'b0);
        checkEq("RI flush", 1, exceptFlush);
        checkEq("RI vector", memStagePkg::VEC_BOOT, exceptVector);
        readCp0(memStagePkg::CP0_EPC, value);
        checkEq("EPC", 32'h8000_3000, value);  // back to the branch
        readCp0(memStagePkg::CP0_CAUSE, value);
        checkEq("BD", 1, value[31]);
        checkEq("ExcCode", memStagePkg::EXC_RI, value[6:2]);
        writeCp0(memStagePkg::CP0_STATUS, statusWord(1'b0, 8'h00, 1'b0, 1'b0), 1'b0);
        b = instrAt(32'h8000_3100);
        b.except.syscall = 1'b1;
        issue(b, 1'b0);
        checkEq("SYS flush", 1, exceptFlush);
        checkEq("normal vector", memStagePkg::VEC_NORMAL, exceptVector);
    endtask

    task automatic flushAndStall();
        memStagePkg::exeMemBus_t b;
        testName = "flushAndStall";
        b           = instrAt(32'h8000_4000);
        b.aluOut    = 32'h8000_0080;
        b.storeType = memStagePkg::ST_W;
        @(posedge clk);
        #DRIVE_DELAY;
        exeIn        = b;
        memWr        = 1'b1;
        disableWrite = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b1;
        memWr = 1'b0;
        @(negedge clk);
        checkEq("write before flush", 1, dmemReq.write);
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        @(negedge clk);
        checkEq("flushed write", 0, dmemReq.write);
        checkEq("flushed read", 0, dmemReq.read);
        checkEq("flushed valid", 0, memOut.valid);
        b          = instrAt(32'h8000_4010);
        b.aluOut   = 32'hA000_0000 | ($random(seed) & 32'h00FF_FFFC);
        b.loadType = memStagePkg::LD_W;
        @(posedge clk);
        #DRIVE_DELAY;
        exeIn = b;
        memWr = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        memWr = 1'b0;         // stall
        exeIn = nopBundle();
        repeat (3) begin
            @(negedge clk);
            checkEq("held read", 1, dmemReq.read);
            checkEq("held physAddr", physOf(b.aluOut), dmemReq.physAddr);
            @(posedge clk);
        end
    endtask

    initial begin
        #(CLK_PERIOD * MAX_CYCLES);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        memStagePkg::word_t value;
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        memWr        = 1'b0;
        disableWrite = 1'b0;
        interrupt    = 6'b0;
        exeIn        = nopBundle();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        checkEq("valid", 0, memOut.valid);
        checkEq("read", 0, dmemReq.read);
        checkEq("write", 0, dmemReq.write);
        checkEq("flush", 0, exceptFlush);
        readCp0(memStagePkg::CP0_STATUS, value);
        checkEq("Status", statusWord(1'b1, 8'h00, 1'b0, 1'b0), value);
        readCp0(memStagePkg::CP0_CAUSE, value);
        checkEq("Cause", 0, value);
        readCp0(memStagePkg::CP0_EPC, value);
        checkEq("EPC", 0, value);

        storesAndMapping();
        testName = "misaligned";
        misalignedCase(1'b0, 32'h8000_2000, 32'h8000_1002 | ($random(seed) & 32'h000F_FFF0));
        misalignedCase(1'b1, 32'h8000_2010, 32'hA000_0001 | ($random(seed) & 32'h000F_FFF0));
        mtc0RoundTrip();
        interruptAndEret();
        delaySlotFault();
        flushAndStall();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/memStagePkg.sv
source/memStageReg.sv
source/dataAddrMap.sv
source/storeLaneAlign.sv
source/cp0Regs.sv
source/exceptionArbiter.sv
source/memStageTop.sv
verif/memStageTb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - source/memStagePkg.sv
  - source/memStageReg.sv
  - source/dataAddrMap.sv
  - source/storeLaneAlign.sv
  - source/cp0Regs.sv
  - source/exceptionArbiter.sv
  - source/memStageTop.sv
  - target: test
    files:
      - verif/memStageTb.sv
